//--- include/pcs_params.svh
`ifndef PCS_PARAMS_SVH
`define PCS_PARAMS_SVH

//////////////////////////////////////////////////
// Line code widths

// Recovered serial word per lane0_rxclk
`define LANE_WIDTH 32
// Gearbox chunk, half a coded block
`define CHUNK_WIDTH 33
`define BLOCK_WIDTH 66
`define PAYLOAD_WIDTH 64
`define HEADER_WIDTH 2

//////////////////////////////////////////////////
// Scrambler polynomial x^58 + x^39 + 1

`define SCRAMBLER_TAP_A 39
`define SCRAMBLER_TAP_B 58

//////////////////////////////////////////////////
// Block lock state machine

// Good headers in a row before lock
`define LOCK_GOOD_COUNT 64
// Blocks per bad header window while locked
`define UNLOCK_WINDOW 64
// Bad headers in one window that drop lock
`define UNLOCK_BAD_COUNT 16
// Blocks ignored after each slip
`define SLIP_HOLDOFF 4

`endif

//--- hdl/pcs_pkg.sv
`include "pcs_params.svh"

package pcs_pkg;

	// One recovered word, bit 31 first on the wire
	typedef logic [`LANE_WIDTH-1:0] lane_word_t;

	// Half block, only seen inside the gearbox
	typedef logic [`CHUNK_WIDTH-1:0] chunk_t;

	// 01 and 10 are legal, 00 and 11 mark misalignment or line errors
	typedef logic [`HEADER_WIDTH-1:0] sync_header_t;

	typedef logic [`PAYLOAD_WIDTH-1:0] block_payload_t;

	// Framed block straight off the gearbox
	// Payload still scrambled
	typedef struct packed {
		logic           valid;
		sync_header_t   header;
		block_payload_t payload;
	} coded_block_t;

	// Same layout after the descrambler
	typedef struct packed {
		logic           valid;
		sync_header_t   header;
		block_payload_t payload;
	} rx_block_t;

	// Block sync FSM
	typedef enum logic [1:0] {
		ALIGN_HUNT,
		ALIGN_SLIP_WAIT,
		ALIGN_LOCKED
	} align_state_t;

endpackage

//--- hdl/rx_block_gearbox.sv
`timescale 1ns/1ps
`include "pcs_params.svh"

module rx_block_gearbox(
	input  logic                  lane0_rxclk,
	input  logic                  reset,
	input  pcs_pkg::lane_word_t   rx_data,
	input  logic                  bitslip,
	output pcs_pkg::coded_block_t coded_block
);

	// Reservoir never holds more than one word of leftovers
	localparam int RES_WIDTH  = 2 * `LANE_WIDTH;
	localparam int FILL_WIDTH = $clog2(RES_WIDTH + 1);

	//////////////////////////////////////////////////
	// 32 to 33 bit reservoir

	// Leftover bits, oldest at fill-1, LSB aligned
	logic [`LANE_WIDTH-1:0] reservoir;
	logic [FILL_WIDTH-1:0]  fill;

	// Leftovers followed by the new word
	logic [RES_WIDTH-1:0]   combined;
	logic [FILL_WIDTH-1:0]  total;
	logic [RES_WIDTH-1:0]   aligned;
	logic                   chunk_ready;
	logic [FILL_WIDTH-1:0]  fill_next;

	pcs_pkg::chunk_t        chunk;
	logic                   chunk_valid;

	always_comb begin
		combined = {reservoir, rx_data};
		// A slip just forgets the oldest bit in hand
		total = fill + FILL_WIDTH'(`LANE_WIDTH) - FILL_WIDTH'(bitslip);
		chunk_ready = (total >= FILL_WIDTH'(`CHUNK_WIDTH));
		// Oldest 33 bits down to the bottom
		// Shift is junk when no chunk is ready, never used then
		aligned = combined >> (total - FILL_WIDTH'(`CHUNK_WIDTH));
		if (chunk_ready)
			fill_next = total - FILL_WIDTH'(`CHUNK_WIDTH);
		else
			fill_next = total;
	end

	//////////////////////////////////////////////////
	// 33 to 66 bit pairing

	// Low means next chunk is the first half of a block
	logic                    phase;
	pcs_pkg::chunk_t         first_chunk;
	logic [`BLOCK_WIDTH-1:0] block_data;
	logic                    block_valid;

	// Datapath
	always_ff @(posedge lane0_rxclk) begin
		// Whatever remains is always in the low word
		reservoir <= combined[`LANE_WIDTH-1:0];
		chunk <= aligned[`CHUNK_WIDTH-1:0];

		// First half goes to bits 65:33
		if (chunk_valid && !phase)
			first_chunk <= chunk;

		// Second half completes the block
		if (chunk_valid && phase)
			block_data <= {first_chunk, chunk};
	end

	// Control
	always_ff @(posedge lane0_rxclk) begin
		if (reset) begin
			fill <= '0;
			chunk_valid <= 1'b0;
			phase <= 1'b0;
			block_valid <= 1'b0;
		end else begin
			fill <= fill_next;
			chunk_valid <= chunk_ready;
			block_valid <= chunk_valid && phase;
			if (chunk_valid)
				phase <= !phase;
		end
	end

	// Header leads the block on the wire
	assign coded_block.valid   = block_valid;
	assign coded_block.header  = block_data[`BLOCK_WIDTH-1 -: `HEADER_WIDTH];
	assign coded_block.payload = block_data[`PAYLOAD_WIDTH-1:0];

endmodule

//--- hdl/block_aligner.sv
`timescale 1ns/1ps
`include "pcs_params.svh"

module block_aligner(
	input  logic                  lane0_rxclk,
	input  logic                  reset,
	input  pcs_pkg::coded_block_t coded_block,
	output logic                  bitslip,
	output logic                  block_lock
);

	localparam int GOOD_WIDTH    = $clog2(`LOCK_GOOD_COUNT);
	localparam int WINDOW_WIDTH  = $clog2(`UNLOCK_WINDOW);
	localparam int BAD_WIDTH     = $clog2(`UNLOCK_BAD_COUNT);
	localparam int HOLDOFF_WIDTH = $clog2(`SLIP_HOLDOFF);

	// Terminal counts, compared before the increment
	localparam logic [GOOD_WIDTH-1:0]    GOOD_LAST    = GOOD_WIDTH'(`LOCK_GOOD_COUNT - 1);
	localparam logic [WINDOW_WIDTH-1:0]  WINDOW_LAST  = WINDOW_WIDTH'(`UNLOCK_WINDOW - 1);
	localparam logic [BAD_WIDTH-1:0]     BAD_LAST     = BAD_WIDTH'(`UNLOCK_BAD_COUNT - 1);
	localparam logic [HOLDOFF_WIDTH-1:0] HOLDOFF_LAST = HOLDOFF_WIDTH'(`SLIP_HOLDOFF - 1);

	pcs_pkg::align_state_t state;

	logic [GOOD_WIDTH-1:0]    good_count;
	logic [WINDOW_WIDTH-1:0]  window_count;
	logic [BAD_WIDTH-1:0]     bad_count;
	logic [HOLDOFF_WIDTH-1:0] holdoff_count;

	// Exactly one transition in the header
	logic header_good;
	assign header_good = coded_block.header[1] ^ coded_block.header[0];

	//////////////////////////////////////////////////
	// Block sync FSM

	always_ff @(posedge lane0_rxclk) begin
		if (reset) begin
			state <= pcs_pkg::ALIGN_HUNT;
			bitslip <= 1'b0;
			good_count <= '0;
			window_count <= '0;
			bad_count <= '0;
			holdoff_count <= '0;
		end else begin
			// Single cycle pulse
			bitslip <= 1'b0;

			if (coded_block.valid) begin
				case (state)

					// Need an unbroken run of good headers
					pcs_pkg::ALIGN_HUNT: begin
						if (!header_good) begin
							bitslip <= 1'b1;
							good_count <= '0;
							holdoff_count <= '0;
							state <= pcs_pkg::ALIGN_SLIP_WAIT;
						end else if (good_count == GOOD_LAST) begin
							good_count <= '0;
							window_count <= '0;
							bad_count <= '0;
							state <= pcs_pkg::ALIGN_LOCKED;
						end else
							good_count <= good_count + 1'b1;
					end

					// Blocks still in the gearbox predate the slip
					pcs_pkg::ALIGN_SLIP_WAIT: begin
						if (holdoff_count == HOLDOFF_LAST)
							state <= pcs_pkg::ALIGN_HUNT;
						else
							holdoff_count <= holdoff_count + 1'b1;
					end

					// Too many bad headers in one window drops lock
					pcs_pkg::ALIGN_LOCKED: begin
						if (!header_good && (bad_count == BAD_LAST)) begin
							good_count <= '0;
							state <= pcs_pkg::ALIGN_HUNT;
						end else if (window_count == WINDOW_LAST) begin
							// Fresh window
							window_count <= '0;
							bad_count <= '0;
						end else begin
							window_count <= window_count + 1'b1;
							if (!header_good)
								bad_count <= bad_count + 1'b1;
						end
					end

					default: state <= pcs_pkg::ALIGN_HUNT;

				endcase
			end
		end
	end

	// Straight decode of the state register
	assign block_lock = (state == pcs_pkg::ALIGN_LOCKED);

endmodule

//--- hdl/block_descrambler.sv
`timescale 1ns/1ps
`include "pcs_params.svh"

module block_descrambler(
	input  logic                  lane0_rxclk,
	input  logic                  reset,
	input  pcs_pkg::coded_block_t coded_block,
	output pcs_pkg::rx_block_t    rx_block
);

	// Last 58 scrambled bits, bit 0 the most recent
	logic [`SCRAMBLER_TAP_B-1:0] history;
	logic [`SCRAMBLER_TAP_B-1:0] history_next;
	pcs_pkg::block_payload_t     plain;

	logic                        out_valid;
	pcs_pkg::sync_header_t       out_header;
	pcs_pkg::block_payload_t     out_payload;

	//////////////////////////////////////////////////
	// Serial descramble, one payload bit per step

	always_comb begin
		history_next = history;
		// Bit 63 is first on the wire
		for (int i = `PAYLOAD_WIDTH - 1; i >= 0; i--) begin
			plain[i] = coded_block.payload[i]
				^ history_next[`SCRAMBLER_TAP_A-1]
				^ history_next[`SCRAMBLER_TAP_B-1];
			// Self-synchronous, so the line bit goes into history
			history_next = {history_next[`SCRAMBLER_TAP_B-2:0], coded_block.payload[i]};
		end
	end

	always_ff @(posedge lane0_rxclk) begin
		if (reset) begin
			history <= '0;
			out_valid <= 1'b0;
		end else begin
			out_valid <= coded_block.valid;
			if (coded_block.valid)
				history <= history_next;
		end
	end

	// Header is not scrambled
	always_ff @(posedge lane0_rxclk) begin
		if (coded_block.valid) begin
			out_header <= coded_block.header;
			out_payload <= plain;
		end
	end

	assign rx_block.valid   = out_valid;
	assign rx_block.header  = out_header;
	assign rx_block.payload = out_payload;

endmodule

//--- hdl/pcs_rx_64b66b.sv
`timescale 1ns/1ps

module pcs_rx_64b66b(
	input  logic                lane0_rxclk,
	input  logic                reset,
	input  pcs_pkg::lane_word_t rx_data,
	output pcs_pkg::rx_block_t  rx_block,
	output logic                block_lock
);

	//////////////////////////////////////////////////
	// Internal links

	// Framed blocks, to aligner and descrambler alike
	pcs_pkg::coded_block_t coded_block;

	// Aligner asks the gearbox to drop one bit
	logic bitslip;

	//////////////////////////////////////////////////
	// Gearbox, 32 bit words in, 66 bit blocks out

	rx_block_gearbox rx_block_gearbox_inst(
		.lane0_rxclk(lane0_rxclk),
		.reset(reset),
		.rx_data(rx_data),
		.bitslip(bitslip),
		.coded_block(coded_block)
	);

	//////////////////////////////////////////////////
	// Sync header lock

	block_aligner block_aligner_inst(
		.lane0_rxclk(lane0_rxclk),
		.reset(reset),
		.coded_block(coded_block),
		.bitslip(bitslip),
		.block_lock(block_lock)
	);

	//////////////////////////////////////////////////
	// Payload descrambler
	// Output not gated by lock

	block_descrambler block_descrambler_inst(
		.lane0_rxclk(lane0_rxclk),
		.reset(reset),
		.coded_block(coded_block),
		.rx_block(rx_block)
	);

endmodule

//--- dv/pcs_rx_64b66b_properties.sv
`timescale 1ns/1ps

module pcs_rx_64b66b_properties(
	input logic               lane0_rxclk,
	input logic               reset,
	input logic               bitslip,
	input logic               block_lock,
	input pcs_pkg::rx_block_t rx_block
);

	// Failed assertions so far
	int failure_count = 0;

	//////////////////////////////////////////////////
	// Aligner slip control

	// Slip request is a single pulse
	slip_single_pulse: assert property (
		@(posedge lane0_rxclk) disable iff (reset)
		bitslip |=> !bitslip
	) else begin
		failure_count++;
		$error("bitslip was high in two consecutive cycles");
	end

	// No slipping once framed
	slip_unlocked_only: assert property (
		@(posedge lane0_rxclk) disable iff (reset)
		!(bitslip && block_lock)
	) else begin
		failure_count++;
		$error("bitslip was high while block_lock was high");
	end

	//////////////////////////////////////////////////
	// Output framing

	// Blocks arrive at most every other cycle
	rx_valid_spacing: assert property (
		@(posedge lane0_rxclk) disable iff (reset)
		rx_block.valid |=> !rx_block.valid
	) else begin
		failure_count++;
		$error("rx_block.valid was high in two consecutive cycles");
	end

endmodule

bind pcs_rx_64b66b pcs_rx_64b66b_properties pcs_rx_64b66b_properties_inst(
	.lane0_rxclk(lane0_rxclk),
	.reset(reset),
	.bitslip(bitslip),
	.block_lock(block_lock),
	.rx_block(rx_block)
);

//--- dv/tb_pcs_rx_64b66b.sv
`timescale 1ns/1ps
`include "pcs_params.svh"

module tb_pcs_rx_64b66b;

	//////////////////////////////////////////////////
	// Test lengths and time limits

	localparam int LOCK_STAY_BLOCKS = 32;
	localparam int INTEGRITY_BLOCKS = 128;
	localparam int TOLERATE_ERRORS  = 8;
	localparam int TOLERATE_SPACING = 8;
	localparam int TOLERATE_TAIL    = 64;
	localparam int CORRUPT_RUN      = 40;
	localparam int RECOVER_BLOCKS   = 32;
	// Worst case walk over all 66 offsets and then a full good run
	localparam int LOCK_BOUND_CYCLES =
		(66 * (`SLIP_HOLDOFF + 2) + `LOCK_GOOD_COUNT) * 3;
	localparam int LOCK_WAITS = 2;
	// Pipeline and resync slack included
	localparam int TEST_BLOCKS = LOCK_STAY_BLOCKS + INTEGRITY_BLOCKS
		+ TOLERATE_ERRORS * TOLERATE_SPACING + TOLERATE_TAIL
		+ CORRUPT_RUN + RECOVER_BLOCKS + 64;
	localparam int WATCHDOG_CYCLES = LOCK_BOUND_CYCLES * LOCK_WAITS + TEST_BLOCKS * 3;

	logic                lane0_rxclk;
	logic                reset;
	pcs_pkg::lane_word_t rx_data;
	pcs_pkg::rx_block_t  rx_block;
	logic                block_lock;

	// Line bits waiting to be sent, oldest first
	logic bit_fifo[$];
	// Scrambler history of line bits with bit 0 newest
	logic [`SCRAMBLER_TAP_B-1:0] scr_state = '0;
	pcs_pkg::sync_header_t   exp_header[$];
	pcs_pkg::block_payload_t exp_payload[$];

	int corrupt_count = 0;
	int blocks_sent = 0;
	int checked_count = 0;
	int skip_count = 0;
	logic track = 1'b0;
	logic synced = 1'b0;
	logic lock_expected = 1'b0;

	// Failures seen by the bound assertions
	int assertion_failures;

	pcs_rx_64b66b pcs_rx_64b66b_inst(
		.lane0_rxclk(lane0_rxclk),
		.reset(reset),
		.rx_data(rx_data),
		.rx_block(rx_block),
		.block_lock(block_lock)
	);

	assign assertion_failures = pcs_rx_64b66b_inst.pcs_rx_64b66b_properties_inst.failure_count;

	always #10 lane0_rxclk = ~lane0_rxclk;

	//////////////////////////////////////////////////
	// Reporting

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("*** TEST FAILED ***");
		$fatal(1, "run aborted");
	endtask

	task automatic check_value(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected)
			abort_run($sformatf("Error: %s is 0x%0h, expected 0x%0h",
				name, actual, expected));
	endtask

	//////////////////////////////////////////////////
	// Block source

	// Raw header then payload scrambled by x^58 + x^39 + 1 in MSB first order
	task automatic append_block(input pcs_pkg::sync_header_t header,
		input pcs_pkg::block_payload_t payload);
		logic line_bit;
		bit_fifo.push_back(header[1]);
		bit_fifo.push_back(header[0]);
		for (int i = `PAYLOAD_WIDTH - 1; i >= 0; i--) begin
			line_bit = payload[i] ^ scr_state[`SCRAMBLER_TAP_A-1]
				^ scr_state[`SCRAMBLER_TAP_B-1];
			scr_state = {scr_state[`SCRAMBLER_TAP_B-2:0], line_bit};
			bit_fifo.push_back(line_bit);
		end
	endtask

	task automatic generate_block();
		pcs_pkg::sync_header_t   header;
		pcs_pkg::block_payload_t payload;
		header = ($urandom & 1) ? 2'b10 : 2'b01;
		payload = {$urandom, $urandom};
		// Forced bad header
		if (corrupt_count > 0) begin
			header = 2'b00;
			corrupt_count--;
		end
		exp_header.push_back(header);
		exp_payload.push_back(payload);
		// Only recent history matters while not in step
		if (!synced && exp_payload.size() > 256) begin
			void'(exp_header.pop_front());
			void'(exp_payload.pop_front());
		end
		append_block(header, payload);
		blocks_sent++;
	endtask

	// One word per cycle on the falling edge
	always @(negedge lane0_rxclk) begin : drive_words
		pcs_pkg::lane_word_t word;
		while (bit_fifo.size() < `LANE_WIDTH)
			generate_block();
		for (int i = `LANE_WIDTH - 1; i >= 0; i--)
			word[i] = bit_fifo.pop_front();
		rx_data = word;
	end

	//////////////////////////////////////////////////
	// Output monitor

	always @(negedge lane0_rxclk) begin : monitor_output
		int idx;
		if (assertion_failures != 0)
			abort_run("A bound assertion on the DUT failed");
		if (lock_expected)
			check_value("block_lock", block_lock, 1);
		if (track && rx_block.valid) begin
			if (skip_count > 0)
				skip_count--;
			else begin
				// First compared block is searched for
				if (!synced) begin
					idx = -1;
					foreach (exp_payload[i])
						if (idx < 0 && exp_payload[i] == rx_block.payload)
							idx = i;
					if (idx < 0)
						abort_run("Received payload matches no block that was sent");
					repeat (idx) begin
						void'(exp_header.pop_front());
						void'(exp_payload.pop_front());
					end
					synced = 1'b1;
				end
				if (exp_payload.size() == 0)
					abort_run("An output block arrived with no block left to expect");
				check_value("rx_block.header", rx_block.header, exp_header.pop_front());
				check_value("rx_block.payload", rx_block.payload, exp_payload.pop_front());
				checked_count++;
			end
		end
	end

	//////////////////////////////////////////////////
	// Helpers

	task automatic wait_blocks(input int count);
		int target;
		target = blocks_sent + count;
		while (blocks_sent < target)
			@(negedge lane0_rxclk);
	endtask

	task automatic wait_checked(input int count);
		int target;
		target = checked_count + count;
		while (checked_count < target)
			@(negedge lane0_rxclk);
	endtask

	task automatic wait_lock_level(input logic level, input int max_cycles, input string what);
		int cycles;
		cycles = 0;
		while (block_lock !== level) begin
			if (cycles == max_cycles)
				abort_run(what);
			@(negedge lane0_rxclk);
			cycles++;
		end
	endtask

	// Descrambler history may still be filling so two are dropped
	task automatic start_tracking();
		skip_count = 2;
		synced = 1'b0;
		track = 1'b1;
	endtask

	//////////////////////////////////////////////////
	// Directed tests

	task automatic apply_reset();
		reset = 1'b1;
		repeat (4) begin
			@(negedge lane0_rxclk);
			check_value("block_lock", block_lock, 0);
			check_value("rx_block.valid", rx_block.valid, 0);
		end
		reset = 1'b0;
		@(negedge lane0_rxclk);
		check_value("block_lock", block_lock, 0);
		check_value("rx_block.valid", rx_block.valid, 0);
	endtask

	task automatic acquire_lock();
		wait_lock_level(1'b1, LOCK_BOUND_CYCLES,
			"block_lock did not rise within the lock bound");
		lock_expected = 1'b1;
		wait_blocks(LOCK_STAY_BLOCKS);
	endtask

	task automatic verify_payloads();
		start_tracking();
		wait_checked(INTEGRITY_BLOCKS);
	endtask

	// Never more than 8 bad headers in one window
	task automatic tolerate_header_errors();
		repeat (TOLERATE_ERRORS) begin
			corrupt_count = 1;
			wait_blocks(TOLERATE_SPACING);
		end
		wait_checked(TOLERATE_TAIL);
	endtask

	task automatic recover_from_lock_loss();
		track = 1'b0;
		synced = 1'b0;
		lock_expected = 1'b0;
		corrupt_count = CORRUPT_RUN;
		wait_lock_level(1'b0, (CORRUPT_RUN + 8) * 3,
			"block_lock did not fall during bad headers");
		// Clean blocks only from here
		while (corrupt_count > 0)
			@(negedge lane0_rxclk);
		wait_lock_level(1'b1, LOCK_BOUND_CYCLES,
			"block_lock did not rise again after loss");
		lock_expected = 1'b1;
		start_tracking();
		wait_checked(RECOVER_BLOCKS);
	endtask

	//////////////////////////////////////////////////
	// Main sequence

	initial begin : main_sequence
		int skip_bits;
		lane0_rxclk = 1'b0;
		reset = 1'b1;
		rx_data = '0;
		void'($urandom(53));
		// Random start somewhere inside a block
		generate_block();
		generate_block();
		skip_bits = $urandom_range(65, 0);
		repeat (skip_bits)
			void'(bit_fifo.pop_front());

		apply_reset();
		acquire_lock();
		verify_payloads();
		tolerate_header_errors();
		recover_from_lock_loss();

		if (assertion_failures != 0)
			abort_run("A bound assertion on the DUT failed");
		else begin
			$display("*** TEST PASSED ***");
			$finish;
		end
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES + 16)
			@(posedge lane0_rxclk);
		abort_run("Timeout: the run did not finish within the allowed number of cycles");
	end

endmodule

//--- pcs_rx_64b66b.f
+incdir+include
hdl/pcs_pkg.sv
hdl/rx_block_gearbox.sv
hdl/block_aligner.sv
hdl/block_descrambler.sv
hdl/pcs_rx_64b66b.sv
dv/pcs_rx_64b66b_properties.sv
dv/tb_pcs_rx_64b66b.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the 64b/66b receive testbench with Verilator.
# Exit status is nonzero when the build fails or the testbench fails.

cd "$(dirname "$0")" || exit 1

TOP=tb_pcs_rx_64b66b
MDIR=obj_dir
BIN=sim_${TOP}

echo "Building ${TOP} with Verilator"
verilator --binary --timing --assert -Wno-fatal \
	--top-module "${TOP}" \
	--Mdir "${MDIR}" \
	-o "${BIN}" \
	-f pcs_rx_64b66b.f
status=$?
if [ ${status} -ne 0 ]; then
	echo "Verilator build failed with status ${status}"
	exit ${status}
fi

if [ ! -x "${MDIR}/${BIN}" ]; then
	echo "Simulation binary ${MDIR}/${BIN} was not produced"
	exit 1
fi

echo "Running ${TOP}"
"./${MDIR}/${BIN}"
status=$?
if [ ${status} -ne 0 ]; then
	echo "Simulation ended with status ${status}"
	exit ${status}
fi

echo "Simulation finished with status 0"
exit 0
